/* src/agen_config.svh */
// ==================================================
// Size settings for the address generation stage
// Included by the package, the RTL and the testbench
// ==================================================

`ifndef AGEN_CONFIG_SVH
`define AGEN_CONFIG_SVH

// Width of virtual and physical addresses
`define AGEN_ADDR_W 32

// Page offset bits, which gives 4 KiB pages
`define AGEN_PAGE_BITS 12

// Cache line offset bits, for 64 byte lines
`define AGEN_LINE_BITS 6

// Number of entries in the translation buffer
`define AGEN_TLB_DEPTH 4

`endif

/* src/agen_pkg.sv */
// ==================================================
// Shared types of the address generation stage
// Compile this first; modules import it as needed
// ==================================================

`default_nettype none

`include "agen_config.svh"

package agen_pkg;

	// ==================================================
	// Address types
	// ==================================================

	// A virtual or a physical byte address
	typedef logic [`AGEN_ADDR_W-1:0] address_t;

	// A page number, virtual or physical, with the page offset stripped
	typedef logic [`AGEN_ADDR_W-`AGEN_PAGE_BITS-1:0] vpn_t;

	// ==================================================
	// Operation and result codes
	// ==================================================

	// The kind of memory operation selects the address formula
	typedef enum logic [1:0] {
		OP_NONE      = 2'd0,
		OP_LOADSTORE = 2'd1,
		OP_AMO       = 2'd2,
		OP_VINDEX    = 2'd3
	} mem_op_e;

	// Exception reported with each translated address
	// EXC_PRIOR means the operation arrived already carrying a fault
	typedef enum logic [1:0] {
		EXC_NONE       = 2'd0,
		EXC_PAGE_MISS  = 2'd1,
		EXC_WRITE_PROT = 2'd2,
		EXC_PRIOR      = 2'd3
	} exc_code_e;

endpackage

`default_nettype wire

/* src/agen_operands.sv */
// ==================================================
// Operand selection ahead of the address adder
// Picks the base and shifts the index by its scale
// ==================================================

`timescale 1ns/100ps
`default_nettype none

module agen_operands (
	// Forces and selects that come with the operation
	input  wire logic              base_zero_i,
	input  wire logic              pc_rel_i,
	input  wire logic              index_zero_i,
	// Register operands and the program counter
	input  wire agen_pkg::address_t base_i,
	input  wire agen_pkg::address_t pc_i,
	input  wire agen_pkg::address_t index_i,
	// Index scale as a power of two, so 1, 2, 4 or 8 bytes
	input  wire logic [1:0]        scale_i,
	// Operands handed to the adder
	output agen_pkg::address_t     base_o,
	output agen_pkg::address_t     index_o
);

	// ==================================================
	// Base selection
	// ==================================================

	// A zero force wins over the program counter select
	// This lets absolute addressing use the immediate alone
	always_comb begin
		if (base_zero_i) begin
			base_o = '0;
		end else if (pc_rel_i) begin
			// PC relative forms replace the register entirely
			base_o = pc_i;
		end else begin
			base_o = base_i;
		end
	end

	// ==================================================
	// Scaled index
	// ==================================================

	// The index register is shifted by the element size
	// A zero force drops the index term from the sum
	always_comb begin
		if (index_zero_i) begin
			index_o = '0;
		end else begin
			index_o = index_i << scale_i;
		end
	end

endmodule

`default_nettype wire

/* src/agen_adder.sv */
// ==================================================
// Virtual address adder with the next line step
// Loaded on an accepted issue and held until the next
// ==================================================

`timescale 1ns/100ps
`default_nettype none

`include "agen_config.svh"

module agen_adder (
	input  wire logic               clk,
	input  wire logic               rst,
	// Register strobe from the control module
	input  wire logic               load_i,
	input  wire agen_pkg::mem_op_e  op_i,
	input  wire agen_pkg::address_t base_i,
	input  wire agen_pkg::address_t index_i,
	input  wire agen_pkg::address_t imm_i,
	// Vector lane used by indexed vector accesses
	input  wire logic [7:0]         lane_i,
	// Step to the start of the following cache line
	input  wire logic               next_line_i,
	output agen_pkg::address_t      vaddr_o
);

	import agen_pkg::*;

	address_t lane_ext;
	address_t sum;
	address_t stepped;

	// Lane number widened so the product keeps address width
	assign lane_ext = address_t'(lane_i);

	// Address formula per operation kind
	always_comb begin
		case (op_i)
			// Each lane strides by the scaled index
			OP_VINDEX:    sum = base_i + index_i * lane_ext + imm_i;
			// Atomics address memory through the base register only
			OP_AMO:       sum = base_i;
			OP_LOADSTORE: sum = base_i + index_i + imm_i;
			default:      sum = '0;
		endcase
	end

	// Clear the line offset and move to the next line number
	// This is used when an access spills over a line boundary
	always_comb begin
		if (next_line_i) begin
			stepped = {sum[`AGEN_ADDR_W-1:`AGEN_LINE_BITS] + 1'b1, {`AGEN_LINE_BITS{1'b0}}};
		end else begin
			stepped = sum;
		end
	end

	// The address is captured at the issue edge
	always_ff @(posedge clk) begin
		if (rst) begin
			vaddr_o <= '0;
		end else if (load_i) begin
			vaddr_o <= stepped;
		end
	end

endmodule

`default_nettype wire

/* src/agen_tlb.sv */
// ==================================================
// Small fully associative translation buffer
// Filled round robin by strobe, looked up once per op
// ==================================================

`timescale 1ns/100ps
`default_nettype none

`include "agen_config.svh"

module agen_tlb (
	input  wire logic               clk,
	input  wire logic               rst,
	// Lookup request and the address to translate
	input  wire logic               lookup_i,
	input  wire agen_pkg::address_t vaddr_i,
	// Fill strobe with the new entry contents
	input  wire logic               fill_i,
	input  wire agen_pkg::vpn_t     fill_vpn_i,
	input  wire agen_pkg::vpn_t     fill_ppn_i,
	input  wire logic               fill_writable_i,
	// Registered lookup result
	output logic                    result_o,
	output logic                    hit_o,
	output agen_pkg::address_t      paddr_o,
	output logic                    writable_o
);

	import agen_pkg::*;

	localparam int DEPTH = `AGEN_TLB_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Entry storage
	logic [DEPTH-1:0] ent_valid;
	logic [DEPTH-1:0] ent_writable;
	vpn_t             ent_vpn [DEPTH];
	vpn_t             ent_ppn [DEPTH];

	// Round robin victim pointer
	logic [PTR_W-1:0] fill_ptr;
	logic [PTR_W-1:0] fill_idx;
	logic [DEPTH-1:0] fill_match;

	// Lookup compare results
	vpn_t             lookup_vpn;
	logic [DEPTH-1:0] hit_vec;
	vpn_t             hit_ppn;
	logic             hit_wr;

	assign lookup_vpn = vaddr_i[`AGEN_ADDR_W-1:`AGEN_PAGE_BITS];

	// ==================================================
	// Lookup compare
	// ==================================================

	// Every valid entry is compared; at most one can match
	// so the hit data is a plain OR over the matching entries
	always_comb begin
		hit_ppn = '0;
		hit_wr = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			hit_vec[i] = ent_valid[i] && (ent_vpn[i] == lookup_vpn);
			if (hit_vec[i]) begin
				hit_ppn = hit_ppn | ent_ppn[i];
				hit_wr = hit_wr | ent_writable[i];
			end
		end
	end

	// The result is registered, so it shows one cycle after the strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			result_o <= 1'b0;
		end else begin
			result_o <= lookup_i;
		end
	end

	// Physical address is the page frame with the untranslated offset
	always_ff @(posedge clk) begin
		if (lookup_i) begin
			hit_o <= |hit_vec;
			paddr_o <= {hit_ppn, vaddr_i[`AGEN_PAGE_BITS-1:0]};
			writable_o <= hit_wr;
		end
	end

	// ==================================================
	// Fill
	// ==================================================

	// A fill for a page already present rewrites that entry in place
	// Otherwise the entry under the pointer is replaced
	always_comb begin
		fill_idx = fill_ptr;
		for (int i = 0; i < DEPTH; i++) begin
			fill_match[i] = ent_valid[i] && (ent_vpn[i] == fill_vpn_i);
			if (fill_match[i]) begin
				fill_idx = PTR_W'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ent_valid <= '0;
			fill_ptr <= '0;
		end else if (fill_i) begin
			ent_valid[fill_idx] <= 1'b1;
			// Only a new page moves the pointer on to the next oldest entry
			if (!(|fill_match)) begin
				fill_ptr <= (fill_ptr == PTR_W'(DEPTH - 1)) ? '0 : fill_ptr + 1'b1;
			end
		end
	end

	// Entry contents are written at the chosen index
	always_ff @(posedge clk) begin
		if (fill_i) begin
			ent_vpn[fill_idx] <= fill_vpn_i;
			ent_ppn[fill_idx] <= fill_ppn_i;
			ent_writable[fill_idx] <= fill_writable_i;
		end
	end

	// Duplicate pages would make the OR of hit data meaningless
	a_single_hit: assert property (@(posedge clk) disable iff (rst)
		lookup_i |-> $onehot0(hit_vec))
		else $error("agen_tlb: more than one entry hit");

endmodule

`default_nettype wire

/* src/agen_ctrl.sv */
// ==================================================
// Control for one memory operation at a time
// Tracks busy, sticky valid, lookup and exception merge
// ==================================================

`timescale 1ns/100ps
`default_nettype none

module agen_ctrl (
	input  wire logic         clk,
	input  wire logic         rst,
	// Operation issue and the flags that travel with it
	input  wire logic         issue_i,
	input  wire logic         is_store_i,
	input  wire logic         prior_exc_i,
	// Registered results from the translation buffer
	input  wire logic         tlb_result_i,
	input  wire logic         tlb_hit_i,
	input  wire logic         tlb_writable_i,
	// Adder load, lookup strobe and status
	output logic              load_o,
	output logic              lookup_o,
	output logic              addr_valid_o,
	output logic              busy_o,
	output logic              done_o,
	output agen_pkg::exc_code_e exc_o
);

	import agen_pkg::*;

	// First stage of the sticky valid, set at the issue edge
	logic valid_stage1;
	// Flags latched at issue and held through the done cycle
	logic store_q;
	logic prior_q;

	// An issue is taken only while idle and loads the address at the same edge
	assign load_o = issue_i && !busy_o;

	// ==================================================
	// Busy and sticky valid
	// ==================================================

	// The address becomes valid one cycle after the adder loads
	// The lookup fires while the address is valid, and that edge ends the op
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_o <= 1'b0;
			valid_stage1 <= 1'b0;
			addr_valid_o <= 1'b0;
		end else if (lookup_o) begin
			busy_o <= 1'b0;
			valid_stage1 <= 1'b0;
			addr_valid_o <= 1'b0;
		end else begin
			if (load_o) begin
				busy_o <= 1'b1;
				valid_stage1 <= 1'b1;
			end
			addr_valid_o <= valid_stage1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_o) begin
			store_q <= is_store_i;
			prior_q <= prior_exc_i;
		end
	end

	// Valid lasts a single cycle, so it doubles as the lookup strobe
	assign lookup_o = addr_valid_o;

	// ==================================================
	// Exception merge and completion
	// ==================================================

	// A fault carried in with the op hides any translation fault
	always_comb begin
		if (prior_q) begin
			exc_o = EXC_PRIOR;
		end else if (!tlb_hit_i) begin
			exc_o = EXC_PAGE_MISS;
		end else if (store_q && !tlb_writable_i) begin
			exc_o = EXC_WRITE_PROT;
		end else begin
			exc_o = EXC_NONE;
		end
	end

	// Completion is the cycle in which the registered result shows
	assign done_o = tlb_result_i;

	a_issue_idle: assert property (@(posedge clk) disable iff (rst)
		issue_i |-> !busy_o)
		else $warning("agen_ctrl: issue while busy was ignored");

	// Each lookup is answered exactly one cycle later
	a_lookup_done: assert property (@(posedge clk) disable iff (rst)
		lookup_o |=> done_o)
		else $error("agen_ctrl: lookup without a result");

	a_done_lookup: assert property (@(posedge clk) disable iff (rst)
		done_o |-> $past(lookup_o))
		else $error("agen_ctrl: done without a lookup");

endmodule

`default_nettype wire

/* src/agen_unit.sv */
// ==================================================
// Top level of the address generation stage
// Connects operands, adder, translation buffer, control
// ==================================================

`timescale 1ns/100ps
`default_nettype none

module agen_unit (
	input  wire logic               clk,
	input  wire logic               rst,
	// Operation inputs
	input  wire logic               issue_i,
	input  wire agen_pkg::mem_op_e  op_i,
	input  wire logic               is_store_i,
	input  wire logic               base_zero_i,
	input  wire logic               pc_rel_i,
	input  wire logic               index_zero_i,
	input  wire agen_pkg::address_t base_i,
	input  wire agen_pkg::address_t pc_i,
	input  wire agen_pkg::address_t index_i,
	input  wire logic [1:0]         scale_i,
	input  wire agen_pkg::address_t imm_i,
	input  wire logic [7:0]         lane_i,
	input  wire logic               next_line_i,
	input  wire logic               prior_exc_i,
	// Translation fill
	input  wire logic               fill_i,
	input  wire agen_pkg::vpn_t     fill_vpn_i,
	input  wire agen_pkg::vpn_t     fill_ppn_i,
	input  wire logic               fill_writable_i,
	// Results and status
	output agen_pkg::address_t      vaddr_o,
	output logic                    addr_valid_o,
	output logic                    done_o,
	output agen_pkg::address_t      paddr_o,
	output agen_pkg::exc_code_e     exc_o,
	output logic                    busy_o
);

	import agen_pkg::*;

	// Datapath operands
	address_t sel_base;
	address_t sel_index;
	// Control and translation handshake
	logic     load;
	logic     lookup;
	logic     tlb_result;
	logic     tlb_hit;
	logic     tlb_writable;

	agen_operands u_operands (
		.base_zero_i  (base_zero_i),
		.pc_rel_i     (pc_rel_i),
		.index_zero_i (index_zero_i),
		.base_i       (base_i),
		.pc_i         (pc_i),
		.index_i      (index_i),
		.scale_i      (scale_i),
		.base_o       (sel_base),
		.index_o      (sel_index)
	);

	agen_adder u_adder (
		.clk         (clk),
		.rst         (rst),
		.load_i      (load),
		.op_i        (op_i),
		.base_i      (sel_base),
		.index_i     (sel_index),
		.imm_i       (imm_i),
		.lane_i      (lane_i),
		.next_line_i (next_line_i),
		.vaddr_o     (vaddr_o)
	);

	// The buffer translates the registered virtual address
	agen_tlb u_tlb (
		.clk             (clk),
		.rst             (rst),
		.lookup_i        (lookup),
		.vaddr_i         (vaddr_o),
		.fill_i          (fill_i),
		.fill_vpn_i      (fill_vpn_i),
		.fill_ppn_i      (fill_ppn_i),
		.fill_writable_i (fill_writable_i),
		.result_o        (tlb_result),
		.hit_o           (tlb_hit),
		.paddr_o         (paddr_o),
		.writable_o      (tlb_writable)
	);

	agen_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.issue_i        (issue_i),
		.is_store_i     (is_store_i),
		.prior_exc_i    (prior_exc_i),
		.tlb_result_i   (tlb_result),
		.tlb_hit_i      (tlb_hit),
		.tlb_writable_i (tlb_writable),
		.load_o         (load),
		.lookup_o       (lookup),
		.addr_valid_o   (addr_valid_o),
		.busy_o         (busy_o),
		.done_o         (done_o),
		.exc_o          (exc_o)
	);

endmodule

`default_nettype wire

/* bench/agen_tb.sv */
// ==================================================
// Testbench for the address generation stage
// Reads fills and operations from the cases file,
// runs each one and compares against its expected row
// ==================================================

`timescale 1ns/100ps
`default_nettype none

`include "agen_config.svh"

module agen_tb;

	import agen_pkg::*;

	// Cycles allowed from issue to done before giving up
	localparam int DONE_LIMIT = 20;
	localparam int LINE_LIMIT = 500;

	logic     clk;
	logic     rst;
	logic     issue_i;
	mem_op_e  op_i;
	logic     is_store_i;
	logic     base_zero_i;
	logic     pc_rel_i;
	logic     index_zero_i;
	address_t base_i;
	address_t pc_i;
	address_t index_i;
	logic [1:0] scale_i;
	address_t imm_i;
	logic [7:0] lane_i;
	logic     next_line_i;
	logic     prior_exc_i;
	logic     fill_i;
	vpn_t     fill_vpn_i;
	vpn_t     fill_ppn_i;
	logic     fill_writable_i;
	address_t vaddr_o;
	logic     addr_valid_o;
	logic     done_o;
	address_t paddr_o;
	exc_code_e exc_o;
	logic     busy_o;

	// Fields of the case being run, as read from the file
	logic [1:0] c_op;
	logic       c_st, c_bz, c_pcr, c_iz, c_nl, c_pe;
	address_t   c_base, c_pc, c_index, c_imm, c_vaddr, c_paddr;
	logic [1:0] c_scale;
	logic [7:0] c_lane;
	logic [1:0] c_exc;
	vpn_t       f_vpn, f_ppn;
	logic       f_wr;

	int    pass_count;
	int    fail_count;
	int    case_errors;
	bit    aborted;
	int    fd;
	int    n;
	int    ch;
	int    lines;
	string name;
	string kind;

	agen_unit uut (.*);

	// 8 ns clock period
	always #4 clk = ~clk;

	// Compares one value and reports a mismatch at once
	task automatic check_value(input string tname, input string field,
			input logic [`AGEN_ADDR_W-1:0] exp, input logic [`AGEN_ADDR_W-1:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s %s: expected %h, actual %h", tname, field, exp, act);
			case_errors++;
		end
	endtask

	// Fill strobe lasts one cycle; called and left on a falling edge
	task automatic apply_fill(input vpn_t vpn, input vpn_t ppn, input logic wr);
		fill_vpn_i = vpn;
		fill_ppn_i = ppn;
		fill_writable_i = wr;
		fill_i = 1'b1;
		@(negedge clk);
		fill_i = 1'b0;
	endtask

	// ==================================================
	// One operation from issue to done
	// ==================================================

	// With twice set a second issue is held while the unit is busy
	task automatic run_operation(input string tname, input bit twice);
		int  cycles;
		int  quiet;
		bit  seen_done;
		case_errors = 0;
		op_i = mem_op_e'(c_op);
		is_store_i = c_st;
		base_zero_i = c_bz;
		pc_rel_i = c_pcr;
		index_zero_i = c_iz;
		base_i = c_base;
		pc_i = c_pc;
		index_i = c_index;
		scale_i = c_scale;
		imm_i = c_imm;
		lane_i = c_lane;
		next_line_i = c_nl;
		prior_exc_i = c_pe;
		issue_i = 1'b1;
		cycles = 0;
		seen_done = 1'b0;
		while (!seen_done && cycles < DONE_LIMIT) begin
			@(negedge clk);
			cycles++;
			// Valid follows the issue edge by one cycle and ends at done
			check_value(tname, "addr_valid_o", cycles == 2, addr_valid_o);
			check_value(tname, "busy_o", cycles < 3, busy_o);
			if (done_o) begin
				seen_done = 1'b1;
				if (cycles != 3) begin
					$display("%s: done_o came %0d cycles after issue instead of 3", tname, cycles);
					case_errors++;
				end
			end
			if (twice && cycles == 1) begin
				// A different base shows up in vaddr if this issue is taken
				base_i = c_base ^ 32'hffff_f000;
			end else begin
				issue_i = 1'b0;
			end
		end
		issue_i = 1'b0;
		if (!seen_done) begin
			$display("%s: timeout, no done_o within %0d cycles", tname, DONE_LIMIT);
			fail_count++;
			aborted = 1'b1;
			return;
		end
		check_value(tname, "vaddr_o", c_vaddr, vaddr_o);
		// A zero physical address in the file marks a miss and is not compared
		if (c_paddr != '0) begin
			check_value(tname, "paddr_o", c_paddr, paddr_o);
		end
		check_value(tname, "exc_o", c_exc, exc_o);
		// The done pulse is one cycle wide and nothing follows it
		for (quiet = 0; quiet < (twice ? 4 : 1); quiet++) begin
			@(negedge clk);
			if (done_o) begin
				$display("%s: extra done_o pulse after the operation", tname);
				case_errors++;
			end
		end
		if (case_errors == 0) begin
			$display("[PASS] %s", tname);
			pass_count++;
		end else begin
			$display("case %s: %0d checks failed", tname, case_errors);
			fail_count++;
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		issue_i = 1'b0;
		op_i = OP_NONE;
		is_store_i = 1'b0;
		base_zero_i = 1'b0;
		pc_rel_i = 1'b0;
		index_zero_i = 1'b0;
		base_i = '0;
		pc_i = '0;
		index_i = '0;
		scale_i = '0;
		imm_i = '0;
		lane_i = '0;
		next_line_i = 1'b0;
		prior_exc_i = 1'b0;
		fill_i = 1'b0;
		fill_vpn_i = '0;
		fill_ppn_i = '0;
		fill_writable_i = 1'b0;
		pass_count = 0;
		fail_count = 0;
		aborted = 1'b0;
		lines = 0;

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Status right after reset
		case_errors = 0;
		check_value("reset", "addr_valid_o", 1'b0, addr_valid_o);
		check_value("reset", "busy_o", 1'b0, busy_o);
		check_value("reset", "done_o", 1'b0, done_o);
		if (case_errors == 0) begin
			$display("[PASS] reset");
			pass_count++;
		end else begin
			$display("case reset: %0d checks failed", case_errors);
			fail_count++;
		end

		fd = $fopen("bench/agen_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open bench/agen_cases.txt");
			aborted = 1'b1;
		end
		while (!aborted && lines < LINE_LIMIT) begin
			n = $fscanf(fd, "%s", name);
			if (n != 1) begin
				break;
			end
			lines++;
			if (name[0] == "#") begin
				// Comment line, skip to its end
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else begin
				n = $fscanf(fd, "%s", kind);
				if (kind == "F") begin
					n = $fscanf(fd, "%h %h %h", f_vpn, f_ppn, f_wr);
					if (n != 3) begin
						$display("bad fill line for %s in the cases file", name);
						aborted = 1'b1;
					end else begin
						apply_fill(f_vpn, f_ppn, f_wr);
					end
				end else if (kind == "O" || kind == "B") begin
					n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						c_op, c_st, c_bz, c_pcr, c_iz, c_base, c_pc, c_index,
						c_scale, c_imm, c_lane, c_nl, c_pe, c_vaddr, c_paddr, c_exc);
					if (n != 16) begin
						$display("bad operation line for %s in the cases file", name);
						aborted = 1'b1;
					end else begin
						run_operation(name, kind == "B");
					end
				end else begin
					$display("unknown line kind %s for %s in the cases file", kind, name);
					aborted = 1'b1;
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("%0d cases passed, %0d cases failed", pass_count, fail_count);
		if (!aborted && fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/agen_cases.txt */
# F: name F vpn ppn writable (page numbers are 20 bits, all hex)
# O, B: name kind op st bz pcr iz base pc index scale imm lane nl prior vaddr paddr exc
# Kind B issues again while busy. A paddr of 0 means a miss and is not compared
miss_early O 1 0 0 0 1 10000040 00000000 00000000 0 00000000 00 0 0 10000040 00000000 1
fill_a F 10000 80000 1
fill_b F 10001 80123 0
fill_c F 00000 40000 1
fill_d F 20000 55555 1
ls_scale0 O 1 0 0 0 0 10000100 00000000 00000010 0 00000004 00 0 0 10000114 80000114 0
ls_scale1 O 1 0 0 0 0 10000100 00000000 00000010 1 00000008 00 0 0 10000128 80000128 0
ls_scale2 O 1 0 0 0 0 10000100 00000000 00000010 2 0000000c 00 0 0 1000014c 8000014c 0
ls_scale3 O 1 1 0 0 0 10000100 00000000 00000010 3 00000000 00 0 0 10000180 80000180 0
ls_negimm O 1 0 0 0 0 10000100 00000000 00000000 0 fffffff0 00 0 0 100000f0 800000f0 0
ls_basezero O 1 0 1 0 0 12345678 00000000 00000020 2 00000300 00 0 0 00000380 40000380 0
ls_idxzero O 1 0 0 0 1 20000010 00000000 77777777 3 00000008 00 0 0 20000018 55555018 0
ls_pcrel O 1 0 0 1 0 99999999 10000ff0 00000004 0 00000008 00 0 0 10000ffc 80000ffc 0
ls_bz_pc O 1 0 1 1 1 99999999 10000000 00000000 0 00000abc 00 0 0 00000abc 40000abc 0
ls_cross O 1 0 0 0 0 10000ff8 00000000 00000010 0 00000000 00 0 0 10001008 80123008 0
amo_base O 2 1 0 0 0 20000040 00000000 00000005 3 00000100 03 0 0 20000040 55555040 0
vidx_lane0 O 3 0 0 0 0 20000000 00000000 00000008 0 00000004 00 0 0 20000004 55555004 0
vidx_lane5 O 3 0 0 0 0 20000000 00000000 00000008 2 00000004 05 0 0 200000a4 555550a4 0
vidx_lane255 O 3 1 0 0 0 20000000 00000000 00000004 0 00000000 ff 0 0 200003fc 555553fc 0
op_none O 0 0 0 0 0 20000040 00000000 00000005 0 00000100 00 0 0 00000000 40000000 0
nl_plain O 1 0 0 0 1 10000123 00000000 00000000 0 00000000 00 1 0 10000140 80000140 0
nl_aligned O 1 0 0 0 1 10000180 00000000 00000000 0 00000000 00 1 0 100001c0 800001c0 0
nl_page O 1 0 0 0 1 10000fc4 00000000 00000000 0 00000000 00 1 0 10001000 80123000 0
nl_vidx O 3 0 0 0 0 20000000 00000000 00000010 0 00000005 03 1 0 20000040 55555040 0
wp_store O 1 1 0 0 1 10001000 00000000 00000000 0 00000010 00 0 0 10001010 80123010 2
wp_load O 1 0 0 0 1 10001000 00000000 00000000 0 00000010 00 0 0 10001010 80123010 0
miss_page O 1 0 0 0 1 30000000 00000000 00000000 0 00000000 00 0 0 30000000 00000000 1
prior_miss O 1 0 0 0 1 30000000 00000000 00000000 0 00000000 00 0 1 30000000 00000000 3
prior_wp O 1 1 0 0 1 10001000 00000000 00000000 0 00000020 00 0 1 10001020 80123020 3
fill_b_rw F 10001 80124 1
wp_refill O 1 1 0 0 1 10001000 00000000 00000000 0 00000010 00 0 0 10001010 80124010 0
fill_e F 30000 66666 1
evict_new O 1 0 0 0 1 30000000 00000000 00000000 0 00000020 00 0 0 30000020 66666020 0
evict_old O 1 0 0 0 1 10000100 00000000 00000000 0 00000000 00 0 0 10000100 00000000 1
evict_kept O 1 0 0 0 1 20000000 00000000 00000000 0 00000008 00 0 0 20000008 55555008 0
dbl_issue B 1 0 0 0 1 20000100 00000000 00000000 0 00000000 00 0 0 20000100 55555100 0

/* sources.f */
+incdir+src
src/agen_pkg.sv
src/agen_operands.sv
src/agen_adder.sv
src/agen_tlb.sv
src/agen_ctrl.sv
src/agen_unit.sv
bench/agen_tb.sv
